//--- src/pwm_pkg.sv
`default_nettype none

package pwm_pkg;

	typedef logic [15:0] data_t;	// register port word
	typedef logic [3:0]  addr_t;
	typedef logic [15:0] cnt_t;	// duty, period, channel count
	typedef logic [7:0]  div_t;	// prescaler divisor

	localparam int NUM_CH_DEF = 4;

	// register map
	localparam addr_t ADDR_CTRL     = 4'd0;	// channel enables in low bits
	localparam addr_t ADDR_PRESC    = 4'd1;
	localparam addr_t ADDR_IRQ_EN   = 4'd2;
	localparam addr_t ADDR_IRQ_STAT = 4'd3;	// write one to clear
	localparam addr_t ADDR_CH_BASE  = 4'd8;	// duty at base+2k, period at base+2k+1

endpackage

`default_nettype wire

//--- src/tick_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tick_gen (
	input  wire                 clk,
	input  wire                 rst,
	input  wire pwm_pkg::div_t  i_presc,
	output logic                o_tick
);

	pwm_pkg::div_t cnt;

	// >= also catches a divisor lowered below the running count
	assign o_tick = (cnt >= i_presc);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt <= '0;
		end else if (o_tick) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/pwm_channel.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_channel (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 i_tick,
	input  wire                 i_en,
	input  wire pwm_pkg::cnt_t  i_duty,
	input  wire pwm_pkg::cnt_t  i_period,
	output logic                o_pwm,
	output logic                o_wrap
);

	pwm_pkg::cnt_t cnt;
	pwm_pkg::cnt_t duty_sh;
	pwm_pkg::cnt_t period_sh;
	logic          at_end;
	logic          wrap_q;

	// last tick of the period
	assign at_end = i_tick & (cnt >= period_sh);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cnt       <= '0;
			duty_sh   <= '0;
			period_sh <= '0;
			wrap_q    <= 1'b0;
		end else if (!i_en) begin
			// shadows track the registers so enable starts with fresh values
			cnt       <= '0;
			duty_sh   <= i_duty;
			period_sh <= i_period;
			wrap_q    <= 1'b0;
		end else begin
			wrap_q <= at_end;
			if (at_end) begin
				cnt       <= '0;
				duty_sh   <= i_duty;	// reload at wrap
				period_sh <= i_period;
			end else if (i_tick) begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign o_pwm  = i_en & (cnt < duty_sh);
	assign o_wrap = wrap_q;

endmodule

`default_nettype wire

//--- src/pwm_irq.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_irq #(
	parameter int NUM_CH = 4
) (
	input  wire              clk,
	input  wire              rst,
	input  wire [NUM_CH-1:0] i_wrap,
	input  wire [NUM_CH-1:0] i_irq_en,
	input  wire [NUM_CH-1:0] i_stat_clr,
	output logic [NUM_CH-1:0] o_stat,
	output logic             o_irq
);

	logic [NUM_CH-1:0] stat;

	// set wins over clear
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stat <= '0;
		end else begin
			stat <= (stat & ~i_stat_clr) | i_wrap;
		end
	end

	assign o_stat = stat;
	assign o_irq  = |(stat & i_irq_en);	// masked

endmodule

`default_nettype wire

//--- src/pwm_regs.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_regs #(
	parameter int NUM_CH = 4
) (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                i_cs,
	input  wire                                i_wr,
	input  wire                                i_rd,
	input  wire pwm_pkg::addr_t                i_addr,
	input  wire pwm_pkg::data_t                i_wr_data,
	input  wire [NUM_CH-1:0]                   i_stat,
	output pwm_pkg::data_t                     o_rd_data,
	output pwm_pkg::div_t                      o_presc,
	output logic [NUM_CH-1:0]                  o_ch_en,
	output pwm_pkg::cnt_t [NUM_CH-1:0]         o_duty,
	output pwm_pkg::cnt_t [NUM_CH-1:0]         o_period,
	output logic [NUM_CH-1:0]                  o_irq_en,
	output logic [NUM_CH-1:0]                  o_stat_clr
);

	logic           wr_en;
	logic           rd_en;
	pwm_pkg::data_t rd_mux;

	// channel k register address, sel 0 duty, sel 1 period
	function automatic pwm_pkg::addr_t ch_addr(input int k, input int sel);
		return pwm_pkg::addr_t'(pwm_pkg::ADDR_CH_BASE + 2 * k + sel);
	endfunction

	assign wr_en = i_cs & i_wr;
	assign rd_en = i_cs & i_rd;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_ch_en    <= '0;
			o_presc    <= '0;
			o_irq_en   <= '0;
			o_stat_clr <= '0;
			o_duty     <= '0;
			o_period   <= '0;
		end else begin
			o_stat_clr <= '0;	// one clock only
			if (wr_en) begin
				case (i_addr)
					pwm_pkg::ADDR_CTRL:     o_ch_en    <= i_wr_data[NUM_CH-1:0];
					pwm_pkg::ADDR_PRESC:    o_presc    <= i_wr_data[7:0];
					pwm_pkg::ADDR_IRQ_EN:   o_irq_en   <= i_wr_data[NUM_CH-1:0];
					pwm_pkg::ADDR_IRQ_STAT: o_stat_clr <= i_wr_data[NUM_CH-1:0];
					default: begin
						for (int k = 0; k < NUM_CH; k++) begin
							if (i_addr == ch_addr(k, 0)) begin
								o_duty[k] <= i_wr_data;
							end
							if (i_addr == ch_addr(k, 1)) begin
								o_period[k] <= i_wr_data;
							end
						end
					end
				endcase
			end
		end
	end

	// read-back mux, unmapped stays zero
	always_comb begin
		rd_mux = '0;
		case (i_addr)
			pwm_pkg::ADDR_CTRL:     rd_mux[NUM_CH-1:0] = o_ch_en;
			pwm_pkg::ADDR_PRESC:    rd_mux[7:0]        = o_presc;
			pwm_pkg::ADDR_IRQ_EN:   rd_mux[NUM_CH-1:0] = o_irq_en;
			pwm_pkg::ADDR_IRQ_STAT: rd_mux[NUM_CH-1:0] = i_stat;	// live flags
			default: begin
				for (int k = 0; k < NUM_CH; k++) begin
					if (i_addr == ch_addr(k, 0)) begin
						rd_mux = o_duty[k];
					end
					if (i_addr == ch_addr(k, 1)) begin
						rd_mux = o_period[k];
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_rd_data <= '0;
		end else if (rd_en) begin
			o_rd_data <= rd_mux;	// held until next read
		end
	end

endmodule

`default_nettype wire

//--- src/pwm_bank.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_bank #(
	parameter int NUM_CH = pwm_pkg::NUM_CH_DEF
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 i_cs,
	input  wire                 i_wr,
	input  wire                 i_rd,
	input  wire pwm_pkg::addr_t i_addr,
	input  wire pwm_pkg::data_t i_wr_data,
	output pwm_pkg::data_t      o_rd_data,
	output logic [NUM_CH-1:0]   o_pwm,
	output logic                o_irq
);

	pwm_pkg::div_t                 presc;
	logic                          tick;
	logic [NUM_CH-1:0]             ch_en;
	pwm_pkg::cnt_t [NUM_CH-1:0]    duty;
	pwm_pkg::cnt_t [NUM_CH-1:0]    period;
	logic [NUM_CH-1:0]             irq_en;
	logic [NUM_CH-1:0]             stat_clr;
	logic [NUM_CH-1:0]             stat;
	logic [NUM_CH-1:0]             wrap;

	tick_gen u_tick (
		.clk     (clk),
		.rst     (rst),
		.i_presc (presc),
		.o_tick  (tick)
	);

	pwm_regs #(.NUM_CH(NUM_CH)) u_regs (
		.clk        (clk),
		.rst        (rst),
		.i_cs       (i_cs),
		.i_wr       (i_wr),
		.i_rd       (i_rd),
		.i_addr     (i_addr),
		.i_wr_data  (i_wr_data),
		.i_stat     (stat),
		.o_rd_data  (o_rd_data),
		.o_presc    (presc),
		.o_ch_en    (ch_en),
		.o_duty     (duty),
		.o_period   (period),
		.o_irq_en   (irq_en),
		.o_stat_clr (stat_clr)
	);

	for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
		pwm_channel u_ch (
			.clk      (clk),
			.rst      (rst),
			.i_tick   (tick),
			.i_en     (ch_en[g]),
			.i_duty   (duty[g]),
			.i_period (period[g]),
			.o_pwm    (o_pwm[g]),
			.o_wrap   (wrap[g])
		);
	end

	pwm_irq #(.NUM_CH(NUM_CH)) u_irq (
		.clk        (clk),
		.rst        (rst),
		.i_wrap     (wrap),
		.i_irq_en   (irq_en),
		.i_stat_clr (stat_clr),
		.o_stat     (stat),
		.o_irq      (o_irq)
	);

endmodule

`default_nettype wire

//--- sim/pwm_bank_assert.sv
`timescale 1ns/10ps
`default_nettype none

module pwm_bank_assert #(
	parameter int NUM_CH = 4
) (
	input wire                clk,
	input wire                rst,
	input wire [NUM_CH-1:0]   i_pwm,
	input wire [NUM_CH-1:0]   i_ch_en,
	input wire [NUM_CH-1:0]   i_stat,
	input wire [NUM_CH-1:0]   i_irq_en,
	input wire                i_irq,
	input wire                i_tick,
	input wire pwm_pkg::div_t i_presc
);

	for (genvar g = 0; g < NUM_CH; g++) begin : g_off
		a_pwm_off: assert property (@(posedge clk) disable iff (!rst)
			!i_ch_en[g] |-> !i_pwm[g])
			else $error("pwm output %0d high while its channel is disabled", g);
	end

	a_irq_mask: assert property (@(posedge clk) disable iff (!rst)
		i_irq == |(i_stat & i_irq_en))
		else $error("irq output differs from the enabled status flags");

	// a new divisor may restart the tick at once
	a_tick_width: assert property (@(posedge clk) disable iff (!rst)
		(i_tick && i_presc != 0) |=> (!i_tick || i_presc != $past(i_presc)))
		else $error("tick high for more than one clock");

endmodule

bind pwm_bank pwm_bank_assert #(.NUM_CH(NUM_CH)) u_assert (
	.clk      (clk),
	.rst      (rst),
	.i_pwm    (o_pwm),
	.i_ch_en  (ch_en),
	.i_stat   (stat),
	.i_irq_en (irq_en),
	.i_irq    (o_irq),
	.i_tick   (tick),
	.i_presc  (presc)
);

`default_nettype wire

//--- sim/tb_pwm_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pwm_bank;

	localparam int NUM_CH       = pwm_pkg::NUM_CH_DEF;
	localparam int CLK_PERIOD   = 40;
	localparam int K            = 3;	// periods per window
	localparam int MAX_SPAN     = 40 * 4;	// longest pwm period in clocks
	localparam int N_WIN        = 5;
	localparam int WIN_CLKS     = N_WIN * (K + 1) * MAX_SPAN;	// windows plus settling
	localparam int TIMEOUT_CLKS = 2 * WIN_CLKS + 1000;
	localparam int ALL_CH       = (1 << NUM_CH) - 1;

	logic              clk;
	logic              rst;
	logic              i_cs;
	logic              i_wr;
	logic              i_rd;
	pwm_pkg::addr_t    i_addr;
	pwm_pkg::data_t    i_wr_data;
	pwm_pkg::data_t    o_rd_data;
	logic [NUM_CH-1:0] o_pwm;
	logic              o_irq;

	int seed;
	int checks;
	int errors;
	int duty_v   [NUM_CH];
	int period_v [NUM_CH];
	int high_cnt [NUM_CH];

	pwm_bank #(.NUM_CH(NUM_CH)) dut0 (
		.clk       (clk),
		.rst       (rst),
		.i_cs      (i_cs),
		.i_wr      (i_wr),
		.i_rd      (i_rd),
		.i_addr    (i_addr),
		.i_wr_data (i_wr_data),
		.o_rd_data (o_rd_data),
		.o_pwm     (o_pwm),
		.o_irq     (o_irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin : watchdog
		#(TIMEOUT_CLKS * CLK_PERIOD);
		$display("timeout: tests still running after %0d clocks", TIMEOUT_CLKS);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// high clocks over a number of periods
	function automatic int exp_high(input int duty, input int period, input int presc,
			input int periods);
		int hi;
		hi = (duty < period + 1) ? duty : period + 1;
		return hi * (presc + 1) * periods;
	endfunction

	function automatic int reg_mask(input int a);
		if (a == pwm_pkg::ADDR_CTRL || a == pwm_pkg::ADDR_IRQ_EN) begin
			return ALL_CH;
		end
		if (a == pwm_pkg::ADDR_PRESC) begin
			return 'hff;
		end
		if (a >= pwm_pkg::ADDR_CH_BASE && a < pwm_pkg::ADDR_CH_BASE + 2 * NUM_CH) begin
			return 'hffff;
		end
		return 0;	// unmapped
	endfunction

	function automatic pwm_pkg::addr_t duty_addr(input int c);
		return pwm_pkg::addr_t'(pwm_pkg::ADDR_CH_BASE + 2 * c);
	endfunction

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic reg_write(input pwm_pkg::addr_t a, input pwm_pkg::data_t d);
		@(posedge clk);
		i_cs      <= 1'b1;
		i_wr      <= 1'b1;
		i_addr    <= a;
		i_wr_data <= d;
		@(posedge clk);
		i_cs <= 1'b0;
		i_wr <= 1'b0;
	endtask

	task automatic reg_read(input pwm_pkg::addr_t a, output pwm_pkg::data_t d);
		@(posedge clk);
		i_cs   <= 1'b1;
		i_rd   <= 1'b1;
		i_addr <= a;
		@(posedge clk);
		i_cs <= 1'b0;
		i_rd <= 1'b0;
		@(negedge clk);	// data valid one clock after the strobe
		d = o_rd_data;
	endtask

	task automatic apply_config(input int presc, input int en_mask);
		reg_write(pwm_pkg::ADDR_CTRL, '0);
		reg_write(pwm_pkg::ADDR_PRESC, pwm_pkg::data_t'(presc));
		for (int c = 0; c < NUM_CH; c++) begin
			reg_write(duty_addr(c), pwm_pkg::data_t'(duty_v[c]));
			reg_write(duty_addr(c) + 1'b1, pwm_pkg::data_t'(period_v[c]));
		end
		reg_write(pwm_pkg::ADDR_CTRL, pwm_pkg::data_t'(en_mask));
	endtask

	task automatic measure_channels(input int presc);
		int len [NUM_CH];
		int max_len;
		max_len = 0;
		for (int c = 0; c < NUM_CH; c++) begin
			len[c]      = K * (period_v[c] + 1) * (presc + 1);
			high_cnt[c] = 0;
			if (len[c] > max_len) begin
				max_len = len[c];
			end
		end
		wait_clocks(max_len / K + presc + 2);	// past the first wrap of every channel
		for (int i = 0; i < max_len; i++) begin
			@(negedge clk);
			for (int c = 0; c < NUM_CH; c++) begin
				if (i < len[c] && o_pwm[c]) begin
					high_cnt[c]++;
				end
			end
		end
	endtask

	task automatic expect_eq(input string what, input int got, input int want);
		checks++;
		if (got != want) begin
			errors++;
			$display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		if (errors == err_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d error(s)", name, errors - err_start);
		end
	endtask

	initial begin : main
		int             err_start;
		int             presc;
		int             off;
		int             irq_ch;
		int             other;
		int             wr_val [16];
		pwm_pkg::data_t rd;

		seed      = 76228;
		checks    = 0;
		errors    = 0;
		rst       = 1'b0;
		i_cs      = 1'b0;
		i_wr      = 1'b0;
		i_rd      = 1'b0;
		i_addr    = '0;
		i_wr_data = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
		@(posedge clk);

		err_start = errors;	// register read-back
		for (int a = 0; a < 16; a++) begin
			wr_val[a] = rand_below(65536);
			if (a != pwm_pkg::ADDR_IRQ_STAT) begin
				reg_write(pwm_pkg::addr_t'(a), pwm_pkg::data_t'(wr_val[a]));
			end
		end
		for (int a = 0; a < 16; a++) begin
			if (a != pwm_pkg::ADDR_IRQ_STAT) begin
				reg_read(pwm_pkg::addr_t'(a), rd);
				expect_eq($sformatf("register %0d", a), int'(rd), wr_val[a] & reg_mask(a));
			end
		end
		finish_test("1 register read-back", err_start);

		err_start = errors;	// duty ratio at two prescales
		for (int p = 0; p < 2; p++) begin
			presc = (p == 0) ? 0 : 3;
			for (int c = 0; c < NUM_CH; c++) begin
				duty_v[c]   = rand_below(40);
				period_v[c] = rand_below(40);
			end
			apply_config(presc, ALL_CH);
			measure_channels(presc);
			for (int c = 0; c < NUM_CH; c++) begin
				expect_eq($sformatf("presc %0d ch %0d high count", presc, c), high_cnt[c],
					exp_high(duty_v[c], period_v[c], presc, K));
			end
		end
		finish_test("2 duty ratio", err_start);

		err_start = errors;	// edge duties
		presc = 1;
		for (int c = 0; c < NUM_CH; c++) begin
			period_v[c] = rand_below(40);
		end
		duty_v[0] = 0;
		duty_v[1] = period_v[1] + 1 + rand_below(8);
		duty_v[2] = period_v[2];
		duty_v[3] = period_v[3] + 1;
		apply_config(presc, ALL_CH);
		measure_channels(presc);
		expect_eq("duty 0 high count", high_cnt[0], 0);
		expect_eq("duty above period high count", high_cnt[1],
			K * (period_v[1] + 1) * (presc + 1));
		for (int c = 2; c < NUM_CH; c++) begin
			expect_eq($sformatf("ch %0d high count", c), high_cnt[c],
				exp_high(duty_v[c], period_v[c], presc, K));
		end
		finish_test("3 edge duties", err_start);

		err_start = errors;	// one channel off, the rest unaffected
		presc = rand_below(4);
		off   = rand_below(NUM_CH);
		for (int c = 0; c < NUM_CH; c++) begin
			duty_v[c]   = rand_below(40);
			period_v[c] = rand_below(40);
		end
		duty_v[off] = 1 + rand_below(39);	// would go high if enabled
		apply_config(presc, ALL_CH & ~(1 << off));
		measure_channels(presc);
		for (int c = 0; c < NUM_CH; c++) begin
			if (c == off) begin
				expect_eq($sformatf("disabled ch %0d high count", c), high_cnt[c], 0);
			end else begin
				expect_eq($sformatf("ch %0d high count", c), high_cnt[c],
					exp_high(duty_v[c], period_v[c], presc, K));
			end
		end
		finish_test("4 enable and independence", err_start);

		err_start = errors;	// interrupts
		irq_ch = rand_below(NUM_CH);
		other  = (irq_ch + 1) % NUM_CH;
		duty_v[irq_ch]   = 2;
		period_v[irq_ch] = 5;
		reg_write(pwm_pkg::ADDR_CTRL, '0);
		reg_write(pwm_pkg::ADDR_IRQ_STAT, pwm_pkg::data_t'(ALL_CH));
		reg_write(pwm_pkg::ADDR_IRQ_EN, pwm_pkg::data_t'(1 << irq_ch));
		apply_config(0, 1 << irq_ch);
		wait_clocks(2 * (period_v[irq_ch] + 1) + 4);
		reg_read(pwm_pkg::ADDR_IRQ_STAT, rd);
		expect_eq("status after one period", int'(rd), 1 << irq_ch);
		@(negedge clk);
		expect_eq("o_irq with enabled status", int'(o_irq), 1);
		reg_write(pwm_pkg::ADDR_CTRL, '0);
		reg_write(pwm_pkg::ADDR_IRQ_STAT, pwm_pkg::data_t'(1 << irq_ch));
		reg_read(pwm_pkg::ADDR_IRQ_STAT, rd);
		expect_eq("status after clear", int'(rd), 0);
		@(negedge clk);
		expect_eq("o_irq after clear", int'(o_irq), 0);
		reg_write(pwm_pkg::ADDR_CTRL, pwm_pkg::data_t'(1 << other));
		wait_clocks(2 * (period_v[other] + 1) + 4);
		reg_read(pwm_pkg::ADDR_IRQ_STAT, rd);
		expect_eq("status without irq enable", int'(rd), 1 << other);
		@(negedge clk);
		expect_eq("o_irq with masked status", int'(o_irq), 0);
		finish_test("5 interrupts", err_start);

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/pwm_pkg.sv
src/tick_gen.sv
src/pwm_channel.sv
src/pwm_irq.sv
src/pwm_regs.sv
src/pwm_bank.sv
sim/pwm_bank_assert.sv
sim/tb_pwm_bank.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_pwm_bank
FLIST    := project.f
OBJ_DIR  := obj_dir
LOG      := sim.log
FAIL_MSG := *** FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run the simulation, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF -- '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
